//--- src.f
+incdir+logic
logic/cmac_rt_pkg.sv
logic/cmac_rt_cfg.sv
logic/cmac_rt_lane.sv
logic/cmac_rt_ctrl.sv
logic/cmac_rt_out.sv
tests/tb_clk_gen.sv
tests/tb_cmac_rt_out.sv

//--- Makefile
TOP := tb_cmac_rt_out

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_cmac_rt_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmac_rt_macros.svh"

module tb_cmac_rt_out;

  localparam int RESET_CYCLES = 10;
  // idle cycles allowed for pending done pulses after the table
  localparam int DRAIN_MAX = 16;

  // one stimulus row
  typedef struct packed {
    logic                      cfg_reg_en;
    logic                      cfg_is_wg;
    logic                      pvld;
    logic [`CMAC_RT_LANES-1:0] mask;
    logic [`CMAC_RT_PD_W-1:0]  pd;
  } row_t;

  logic                   nvdla_wg_clk;
  logic                   nvdla_core_rstn;
  logic                   cfg_reg_en;
  logic                   cfg_is_wg;
  cmac_rt_pkg::mac_ctrl_s out_ctrl;
  cmac_rt_pkg::lane_bus_t out_data;
  cmac_rt_pkg::mac_ctrl_s mac2accu_ctrl;
  cmac_rt_pkg::lane_bus_t mac2accu_data;
  logic [7:0]             mac2accu_mode;
  logic                   dp2reg_done;

  row_t        rows[$];
  logic [31:0] rnd_state;
  int          cyc;

  // ====================
  // model state
  // ====================

  cmac_rt_pkg::mac_ctrl_s   exp_ctrl;
  logic                     exp_pd_known;
  cmac_rt_pkg::lane_bus_t   exp_data;
  // segments written since reset, others still unknown
  logic [`CMAC_RT_SEGS-1:0] seg_loaded [`CMAC_RT_LANES];
  logic                     exp_wg_en;
  logic [7:0]               exp_mode;
  // pending config changes, cycle they become visible and new flag
  int                       cfg_due_q[$];
  logic                     cfg_val_q[$];
  // cycles in which a done pulse is due
  int                       done_due[$];

  tb_clk_gen u_clk (
    .clk (nvdla_wg_clk)
  );

  cmac_rt_out dut (
    .nvdla_wg_clk    (nvdla_wg_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_reg_en      (cfg_reg_en),
    .cfg_is_wg       (cfg_is_wg),
    .out_ctrl        (out_ctrl),
    .out_data        (out_data),
    .mac2accu_ctrl   (mac2accu_ctrl),
    .mac2accu_data   (mac2accu_data),
    .mac2accu_mode   (mac2accu_mode),
    .dp2reg_done     (dp2reg_done)
  );

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // fresh partial sums for every lane, built through the flat view
  task automatic make_lane_bus(output cmac_rt_pkg::lane_bus_t d);
    logic [191:0] words;
    for (int i = 0; i < `CMAC_RT_LANES; i++) begin
      for (int w = 0; w < 6; w++) begin
        rnd_state = xorshift32(rnd_state);
        words[w*32 +: 32] = rnd_state;
      end
      d[i].flat = words[`CMAC_RT_LANE_W-1:0];
    end
  endtask

  task automatic add_row(input logic en, input logic wg, input logic pvld,
                         input logic [`CMAC_RT_LANES-1:0] mask,
                         input logic [`CMAC_RT_PD_W-1:0] pd);
    rows.push_back({en, wg, pvld, mask, pd});
  endtask

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // ====================
  // compare tasks
  // ====================

  // descriptor only once a valid beat has set it
  task automatic check_ctrl(input cmac_rt_pkg::mac_ctrl_s got,
                            input cmac_rt_pkg::mac_ctrl_s exp, input logic pd_known);
    if (got.pvld !== exp.pvld || got.mask !== exp.mask ||
        (pd_known && got.pd !== exp.pd)) begin
      $display("** Error: mac2accu_ctrl got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_lane(input int lane, input cmac_rt_pkg::lane_data_u got,
                            input cmac_rt_pkg::lane_data_u exp,
                            input logic [`CMAC_RT_SEGS-1:0] loaded);
    for (int s = 0; s < `CMAC_RT_SEGS; s++) begin
      if (loaded[s] && got.seg[s] !== exp.seg[s]) begin
        $display("** Error: mac2accu_data[%0d].seg[%0d] got %h expected %h",
                 lane, s, got.seg[s], exp.seg[s]);
        abort_run();
      end
    end
  endtask

  task automatic check_mode(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error: mac2accu_mode got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: dp2reg_done got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  // ====================
  // reference model
  // ====================

  // outputs seen now come from the previous cycle's inputs
  task automatic check_outputs();
    logic exp_done;
    // mode change lands two cycles after its strobe
    if (cfg_due_q.size() > 0) begin
      if (cfg_due_q[0] == cyc) begin
        exp_wg_en = cfg_val_q[0];
        exp_mode  = {8{cfg_val_q[0]}};
        void'(cfg_due_q.pop_front());
        void'(cfg_val_q.pop_front());
      end
    end
    exp_done = 1'b0;
    if (done_due.size() > 0) begin
      exp_done = (done_due[0] == cyc);
    end
    check_ctrl(mac2accu_ctrl, exp_ctrl, exp_pd_known);
    for (int i = 0; i < `CMAC_RT_LANES; i++) begin
      check_lane(i, mac2accu_data[i], exp_data[i], seg_loaded[i]);
    end
    check_mode(mac2accu_mode, exp_mode);
    check_done(dp2reg_done, exp_done);
    if (exp_done) begin
      void'(done_due.pop_front());
    end
  endtask

  // predict what this cycle's inputs do at the next edge
  task automatic update_model(input row_t r, input cmac_rt_pkg::lane_bus_t d);
    for (int i = 0; i < `CMAC_RT_LANES; i++) begin
      if (r.mask[i]) begin
        exp_data[i].seg[0] = d[i].seg[0];
        seg_loaded[i][0]   = 1'b1;
        // upper segments need winograd in force this cycle
        if (exp_wg_en) begin
          for (int s = 1; s < `CMAC_RT_SEGS; s++) begin
            exp_data[i].seg[s] = d[i].seg[s];
            seg_loaded[i][s]   = 1'b1;
          end
        end
      end
    end
    exp_ctrl.pvld = r.pvld;
    exp_ctrl.mask = r.mask;
    if (r.pvld) begin
      exp_ctrl.pd  = r.pd;
      exp_pd_known = 1'b1;
    end
    if (r.pvld && r.pd[`CMAC_RT_PD_LAYER_END] && r.pd[`CMAC_RT_PD_CHN_END]) begin
      done_due.push_back(cyc + `CMAC_RT_DONE_DLY);
    end
    if (r.cfg_reg_en) begin
      cfg_due_q.push_back(cyc + 2);
      cfg_val_q.push_back(r.cfg_is_wg);
    end
  endtask

  // drive on the rising edge, check and predict mid-cycle
  task automatic run_cycle(input row_t r, input cmac_rt_pkg::lane_bus_t d);
    @(posedge nvdla_wg_clk);
    cyc = cyc + 1;
    cfg_reg_en    <= r.cfg_reg_en;
    cfg_is_wg     <= r.cfg_is_wg;
    out_ctrl.pvld <= r.pvld;
    out_ctrl.mask <= r.mask;
    out_ctrl.pd   <= r.pd;
    out_data      <= d;
    @(negedge nvdla_wg_clk);
    check_outputs();
    update_model(r, d);
  endtask

  // ====================
  // stimulus table
  // ====================

  task automatic build_table();
    // retimed valid and mask, descriptor holds on idle rows
    add_row(1'b0, 1'b0, 1'b1, 8'hff, 9'h005);
    add_row(1'b0, 1'b0, 1'b0, 8'h0f, 9'h1ff);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h0aa);
    add_row(1'b0, 1'b0, 1'b1, 8'ha5, 9'h012);
    // winograd on, all segments load from two cycles later
    add_row(1'b1, 1'b1, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b1, 8'h3c, 9'h020);
    add_row(1'b0, 1'b0, 1'b1, 8'hff, 9'h021);
    add_row(1'b0, 1'b0, 1'b1, 8'h81, 9'h022);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    // single layer end
    add_row(1'b0, 1'b0, 1'b1, 8'h01, 9'h140);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    // one end bit only, or both without valid
    add_row(1'b0, 1'b0, 1'b1, 8'h02, 9'h100);
    add_row(1'b0, 1'b0, 1'b1, 8'h04, 9'h040);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h140);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    // back-to-back layer ends
    add_row(1'b0, 1'b0, 1'b1, 8'hf0, 9'h141);
    add_row(1'b0, 1'b0, 1'b1, 8'h0f, 9'h1c0);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
    // winograd off again, upper segments freeze
    add_row(1'b1, 1'b0, 1'b1, 8'h55, 9'h033);
    add_row(1'b0, 1'b0, 1'b1, 8'haa, 9'h034);
    add_row(1'b0, 1'b0, 1'b1, 8'hff, 9'h035);
    add_row(1'b0, 1'b0, 1'b1, 8'hff, 9'h036);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 9'h000);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    cmac_rt_pkg::lane_bus_t bus;
    int drain;
    nvdla_core_rstn = 1'b0;
    cfg_reg_en      = 1'b0;
    cfg_is_wg       = 1'b0;
    out_ctrl        = '0;
    out_data        = '0;
    rnd_state       = 32'h1d62_c264;
    cyc             = 0;
    exp_ctrl        = '0;
    exp_pd_known    = 1'b0;
    exp_data        = '0;
    exp_wg_en       = 1'b0;
    exp_mode        = 8'h00;
    for (int i = 0; i < `CMAC_RT_LANES; i++) begin
      seg_loaded[i] = '0;
    end
    build_table();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge nvdla_wg_clk);
    end
    nvdla_core_rstn <= 1'b1;
    foreach (rows[k]) begin
      make_lane_bus(bus);
      run_cycle(rows[k], bus);
    end
    // one idle cycle for the last row's outputs
    // then idle until every expected done pulse has shown up
    drain = 0;
    while (drain == 0 || done_due.size() != 0) begin
      if (drain == DRAIN_MAX) begin
        $display("timeout waiting for the last dp2reg_done pulses");
        abort_run();
      end
      make_lane_bus(bus);
      run_cycle('0, bus);
      drain++;
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  // full clock period in ns
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // starts low, first rising edge after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- logic/cmac_rt_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmac_rt_macros.svh"

module cmac_rt_out (
  input  wire                    nvdla_wg_clk,
  input  wire                    nvdla_core_rstn,
  input  logic                   cfg_reg_en,
  input  logic                   cfg_is_wg,
  input  cmac_rt_pkg::mac_ctrl_s out_ctrl,
  input  cmac_rt_pkg::lane_bus_t out_data,
  output cmac_rt_pkg::mac_ctrl_s mac2accu_ctrl,
  output cmac_rt_pkg::lane_bus_t mac2accu_data,
  output logic [7:0]             mac2accu_mode,
  output logic                   dp2reg_done
);

  // winograd permission shared by all lanes
  logic wg_en;

  // ====================
  // configuration
  // ====================

  // mode register and upper segment permission
  cmac_rt_cfg u_cfg (
    .nvdla_wg_clk    (nvdla_wg_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_reg_en      (cfg_reg_en),
    .cfg_is_wg       (cfg_is_wg),
    .wg_en           (wg_en),
    .mac2accu_mode   (mac2accu_mode)
  );

  // ====================
  // control retiming
  // ====================

  // valid, mask, descriptor and layer done
  cmac_rt_ctrl u_ctrl (
    .nvdla_wg_clk    (nvdla_wg_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .out_ctrl        (out_ctrl),
    .mac2accu_ctrl   (mac2accu_ctrl),
    .dp2reg_done     (dp2reg_done)
  );

  // ====================
  // lane data
  // ====================

  // one retimer per lane
  // enables come from the incoming mask, same cycle as the data
  for (genvar i = 0; i < `CMAC_RT_LANES; i++) begin : g_lane
    cmac_rt_lane u_lane (
      .nvdla_wg_clk (nvdla_wg_clk),
      .lane_mask    (out_ctrl.mask[i]),
      .wg_en        (wg_en),
      .lane_in      (out_data[i]),
      .lane_out     (mac2accu_data[i])
    );
  end

endmodule

`default_nettype wire

//--- logic/cmac_rt_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmac_rt_macros.svh"

module cmac_rt_ctrl (
  input  wire                    nvdla_wg_clk,
  input  wire                    nvdla_core_rstn,
  input  cmac_rt_pkg::mac_ctrl_s out_ctrl,
  output cmac_rt_pkg::mac_ctrl_s mac2accu_ctrl,
  output logic                   dp2reg_done
);

  // retimed control fields
  logic                      rt_pvld;
  logic [`CMAC_RT_LANES-1:0] rt_mask;
  logic [`CMAC_RT_PD_W-1:0]  rt_pd;

  // last beat of the layer seen this cycle
  logic layer_end;
  // done delay line, oldest stage at the top
  logic [`CMAC_RT_DONE_DLY-1:0] done_pipe;

  // ====================
  // valid and mask
  // ====================

  always_ff @(posedge nvdla_wg_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rt_pvld <= 1'b0;
      rt_mask <= '0;
    end else begin
      rt_pvld <= out_ctrl.pvld;
      rt_mask <= out_ctrl.mask;
    end
  end

  // ====================
  // descriptor
  // ====================

  // captured on valid beats only
  // holds the last descriptor through idle cycles
  always_ff @(posedge nvdla_wg_clk) begin
    if (out_ctrl.pvld) begin
      rt_pd <= out_ctrl.pd;
    end
  end

  assign mac2accu_ctrl = '{pvld: rt_pvld, mask: rt_mask, pd: rt_pd};

  // ====================
  // layer done
  // ====================

  // both end bits on a valid beat
  assign layer_end = out_ctrl.pvld
                   & out_ctrl.pd[`CMAC_RT_PD_LAYER_END]
                   & out_ctrl.pd[`CMAC_RT_PD_CHN_END];

  // shift register, one pulse out per layer-end beat
  always_ff @(posedge nvdla_wg_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_pipe <= '0;
    end else begin
      done_pipe <= {done_pipe[`CMAC_RT_DONE_DLY-2:0], layer_end};
    end
  end

  // last stage feeds the register block
  assign dp2reg_done = done_pipe[`CMAC_RT_DONE_DLY-1];

  // back-to-back done only from back-to-back layer ends
  a_done_b2b : assert property (
    @(posedge nvdla_wg_clk) disable iff (!nvdla_core_rstn)
    (dp2reg_done && $past(dp2reg_done)) |->
      ($past(layer_end, `CMAC_RT_DONE_DLY) && $past(layer_end, `CMAC_RT_DONE_DLY + 1))
  );

endmodule

`default_nettype wire

//--- logic/cmac_rt_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmac_rt_macros.svh"

module cmac_rt_lane (
  input  wire                     nvdla_wg_clk,
  input  logic                    lane_mask,
  input  logic                    wg_en,
  input  cmac_rt_pkg::lane_data_u lane_in,
  output cmac_rt_pkg::lane_data_u lane_out
);

  // load enable per segment
  logic [`CMAC_RT_SEGS-1:0] seg_ld;

  // ====================
  // load enables
  // ====================

  // segment 0 carries data in every mode
  assign seg_ld[0] = lane_mask;

  // upper segments only hold winograd partial sums
  assign seg_ld[`CMAC_RT_SEGS-1:1] = {(`CMAC_RT_SEGS-1){lane_mask & wg_en}};

  // ====================
  // segment registers
  // ====================

  // payload only, no reset
  // a segment that is not loaded keeps its last value
  always_ff @(posedge nvdla_wg_clk) begin
    for (int s = 0; s < `CMAC_RT_SEGS; s++) begin
      if (seg_ld[s]) begin
        lane_out.seg[s] <= lane_in.seg[s];
      end
    end
  end

  // ====================
  // checks
  // ====================

  // with winograd off the upper segments are frozen
  // case equality so never-loaded segments compare as equal
  a_wg_off_hold : assert property (
    @(posedge nvdla_wg_clk)
    !wg_en |=> (lane_out.seg[`CMAC_RT_SEGS-1:1] === $past(lane_out.seg[`CMAC_RT_SEGS-1:1]))
  );

endmodule

`default_nettype wire

//--- logic/cmac_rt_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module cmac_rt_cfg (
  input  wire        nvdla_wg_clk,
  input  wire        nvdla_core_rstn,
  input  logic       cfg_reg_en,
  input  logic       cfg_is_wg,
  output logic       wg_en,
  output logic [7:0] mac2accu_mode
);

  // strobe delayed by one cycle
  logic cfg_reg_en_d1;
  // flag sampled on the strobe
  logic cfg_is_wg_d1;

  // ====================
  // capture stage
  // ====================

  always_ff @(posedge nvdla_wg_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg_reg_en_d1 <= 1'b0;
      cfg_is_wg_d1  <= 1'b0;
    end else begin
      cfg_reg_en_d1 <= cfg_reg_en;
      // flag only moves on a register write
      if (cfg_reg_en) begin
        cfg_is_wg_d1 <= cfg_is_wg;
      end
    end
  end

  // ====================
  // apply stage
  // ====================

  // one cycle behind the capture, visible from t+2
  always_ff @(posedge nvdla_wg_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wg_en         <= 1'b0;
      mac2accu_mode <= 8'h00;
    end else if (cfg_reg_en_d1) begin
      // permission for segments 1 to 3 of every lane
      wg_en         <= cfg_is_wg_d1;
      // accumulator wants the flag on all eight bits
      mac2accu_mode <= {8{cfg_is_wg_d1}};
    end
  end

  // strobe must be clean once out of reset
  a_cfg_reg_en_known : assert property (
    @(posedge nvdla_wg_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(cfg_reg_en)
  );

endmodule

`default_nettype wire

//--- logic/cmac_rt_pkg.sv
`default_nettype none

`include "cmac_rt_macros.svh"

package cmac_rt_pkg;

  // ====================
  // lane data
  // ====================

  // one lane of partial sums
  // flat view for bulk moves, segment view for the per-segment enables
  typedef union packed {
    logic [`CMAC_RT_LANE_W-1:0] flat;
    logic [`CMAC_RT_SEGS-1:0][`CMAC_RT_SEG_W-1:0] seg;
  } lane_data_u;

  // all lanes side by side, lane 0 in the low bits
  typedef lane_data_u [`CMAC_RT_LANES-1:0] lane_bus_t;

  // ====================
  // control
  // ====================

  // valid, lane mask and descriptor of one beat
  // pvld sits in the msb
  typedef struct packed {
    // beat valid
    logic pvld;
    // one bit per lane
    logic [`CMAC_RT_LANES-1:0] mask;
    // partial-sum descriptor
    logic [`CMAC_RT_PD_W-1:0] pd;
  } mac_ctrl_s;

endpackage

`default_nettype wire

//--- logic/cmac_rt_macros.svh
`ifndef CMAC_RT_MACROS_SVH
`define CMAC_RT_MACROS_SVH

// ====================
// lane geometry
// ====================

// partial-sum lanes per cycle
`define CMAC_RT_LANES 8
// segments per lane, segment 0 always live
`define CMAC_RT_SEGS 4
// one segment of partial sums
`define CMAC_RT_SEG_W 44
// full lane, 176 bits
`define CMAC_RT_LANE_W (`CMAC_RT_SEGS * `CMAC_RT_SEG_W)

// ====================
// descriptor
// ====================

`define CMAC_RT_PD_W 9
// last data of a layer
`define CMAC_RT_PD_LAYER_END 8
// last data of a channel group
`define CMAC_RT_PD_CHN_END 6
// layer end to done pulse, in cycles
`define CMAC_RT_DONE_DLY 4

`endif
